/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := unlockerTb
FILELIST  := sim.f
OBJDIR    := obj_dir
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* design/credentialMatcher.sv */
module credentialMatcher
    import unlockerPkg::*;
(
    input  logic [codeW-1:0]  names [tableDepth],
    input  logic [codeW-1:0]  passwords [tableDepth],
    input  logic [countW-1:0] count,
    input  logic [codeW-1:0]  nameCode,
    input  logic [codeW-1:0]  passwordCode,
    output logic              nameHit,
    output logic [idxW-1:0]   nameIdx,
    output logic              loginHit,
    output logic [idxW-1:0]   loginIdx
);

    logic [tableDepth-1:0] valid;

    // only slots below count hold live accounts
    always_comb
    begin
        for (int i = 0; i < tableDepth; i++)
        begin
            valid[i] = (i < count);
        end
    end

    always_comb
    begin
        nameHit  = 1'b0;
        nameIdx  = '0;
        loginHit = 1'b0;
        loginIdx = '0;
        // scan downwards so the lowest matching slot is left standing
        for (int i = tableDepth - 1; i >= 0; i--)
        begin
            if (valid[i] && names[i] == nameCode)
            begin
                nameHit = 1'b1;
                nameIdx = idxW'(i);
                if (passwords[i] == passwordCode)
                begin
                    loginHit = 1'b1;
                    loginIdx = idxW'(i);
                end
            end
        end
    end

endmodule

/* design/sessionControl.sv */
module sessionControl
    import unlockerPkg::*;
(
    input  logic              clk,
    input  logic              arstN,
    input  logic              locker,
    input  logic              btn1,
    input  logic              btn2,
    input  logic              btn3,
    input  logic              btn5,
    input  logic [3:0]        inputCount,
    input  logic              flagResolve,
    input  logic              nameHit,
    input  logic              loginHit,
    input  logic [idxW-1:0]   nameIdx,
    input  logic [idxW-1:0]   loginIdx,
    input  userMode_e         modes [tableDepth],
    input  logic [countW-1:0] count,
    output logic              lock,
    output logic              flag,
    output logic              flagSelect,
    output logic              resetCount,
    output logic              addEn,
    output logic              delEn,
    output logic              pwWrEn,
    output logic [idxW-1:0]   curUser
);

    sessionState_e   state;
    logic [1:0]      attempts;   // failed logins in a row
    userMode_e       curMode;
    logic            isAdmin;
    logic            unlocked;
    logic            loginTry;
    logic            lockCmd;
    logic            consume;
    logic [idxW-1:0] lastIdx;

    assign curMode  = modes[curUser];
    assign isAdmin  = (curMode == modeAdmin);
    assign unlocked = (state == stUnlocked);
    assign lastIdx  = idxW'(count - 1'b1);

    assign loginTry = (state == stLocked) && (inputCount == fullEntry);
    assign lockCmd  = unlocked && (locker || btn1);

    // button priority: lock, btn2, btn3, btn5; a refused press still blocks the lower ones
    assign pwWrEn = unlocked && !(locker || btn1) && btn2
                 && (curMode == modeAdmin || curMode == modeUser)
                 && (inputCount >= nameEntry);

    assign addEn = unlocked && !(locker || btn1) && !btn2 && btn3
                && isAdmin && (inputCount == fullEntry)
                && (count < tableDepth) && !nameHit;

    assign delEn = unlocked && !(locker || btn1) && !btn2 && !btn3 && btn5
                && isAdmin && (inputCount == nameEntry)
                && nameHit && (nameIdx != curUser);

    assign consume = loginTry || pwWrEn || addEn || delEn;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state      <= stLocked;
            lock       <= 1'b1;
            flag       <= 1'b0;
            flagSelect <= 1'b0;
            resetCount <= 1'b0;
            attempts   <= '0;
            curUser    <= '0;
        end
        else
        begin
            resetCount <= consume;  // single-cycle pulse per accepted entry
            case (state)
                stLocked:
                begin
                    if (loginTry && loginHit)
                    begin
                        state    <= stUnlocked;
                        lock     <= 1'b0;
                        curUser  <= loginIdx;
                        attempts <= '0;
                    end
                    else if (loginTry)
                    begin
                        state <= stFlagged;
                        flag  <= 1'b1;
                        if (attempts == 2'(maxAttempts - 1))
                        begin
                            flagSelect <= 1'b1;
                            attempts   <= '0;
                        end
                        else
                        begin
                            flagSelect <= 1'b0;
                            attempts   <= attempts + 1'b1;
                        end
                    end
                end
                stUnlocked:
                begin
                    if (lockCmd)
                    begin
                        state <= stLocked;
                        lock  <= 1'b1;
                    end
                    else if (delEn && curUser == lastIdx)
                    begin
                        curUser <= nameIdx;  // we were the moved entry
                    end
                end
                stFlagged:
                begin
                    if (flagResolve)
                    begin
                        state      <= stLocked;
                        flag       <= 1'b0;
                        flagSelect <= 1'b0;
                    end
                end
                default:
                begin
                    state <= stLocked;
                    lock  <= 1'b1;
                end
            endcase
        end
    end

    flagMatchesState: assert property (
        @(posedge clk) disable iff (!arstN)
        flag == (state == stFlagged)
    );

    lockMatchesState: assert property (
        @(posedge clk) disable iff (!arstN)
        !lock == (state == stUnlocked)
    );

    resetCountPulse: assert property (
        @(posedge clk) disable iff (!arstN)
        resetCount |=> !resetCount
    );

endmodule

/* design/unlocker.sv */
module unlocker
    import unlockerPkg::*;
(
    input  logic              clk,
    input  logic              arstN,
    input  logic              locker,
    input  logic              btn1,
    input  logic              btn2,
    input  logic              btn3,
    input  logic              btn4,
    input  logic              btn5,
    input  logic              switch1,
    input  logic [3:0]        inputCount,
    input  logic [digitW-1:0] userNameInput0,
    input  logic [digitW-1:0] userNameInput1,
    input  logic [digitW-1:0] userNameInput2,
    input  logic [digitW-1:0] userNameInput3,
    input  logic [digitW-1:0] passwordInput0,
    input  logic [digitW-1:0] passwordInput1,
    input  logic [digitW-1:0] passwordInput2,
    input  logic [digitW-1:0] passwordInput3,
    input  logic              flagResolve,
    output logic              lock,
    output logic              flag,
    output logic              flagSelect,
    output logic              resetCount
);

    logic [codeW-1:0]  nameCode;
    logic [codeW-1:0]  passwordCode;
    logic [codeW-1:0]  names [tableDepth];
    logic [codeW-1:0]  passwords [tableDepth];
    userMode_e         modes [tableDepth];
    logic [countW-1:0] count;
    logic              nameHit;
    logic              loginHit;
    logic [idxW-1:0]   nameIdx;
    logic [idxW-1:0]   loginIdx;
    logic              addEn;
    logic              delEn;
    logic              pwWrEn;
    logic [idxW-1:0]   curUser;

    // digit 3 is the leading digit
    assign nameCode     = {userNameInput3, userNameInput2, userNameInput1, userNameInput0};
    assign passwordCode = {passwordInput3, passwordInput2, passwordInput1, passwordInput0};

    credentialMatcher i_credentialMatcher (
        .names        (names),
        .passwords    (passwords),
        .count        (count),
        .nameCode     (nameCode),
        .passwordCode (passwordCode),
        .nameHit      (nameHit),
        .nameIdx      (nameIdx),
        .loginHit     (loginHit),
        .loginIdx     (loginIdx)
    );

    userTable i_userTable (
        .clk          (clk),
        .arstN        (arstN),
        .addEn        (addEn),
        .delEn        (delEn),
        .pwWrEn       (pwWrEn),
        .switch1      (switch1),
        .nameCode     (nameCode),
        .passwordCode (passwordCode),
        .nameIdx      (nameIdx),
        .curUser      (curUser),
        .names        (names),
        .passwords    (passwords),
        .modes        (modes),
        .count        (count)
    );

    // btn4 has no function and is left unconnected
    sessionControl i_sessionControl (
        .clk         (clk),
        .arstN       (arstN),
        .locker      (locker),
        .btn1        (btn1),
        .btn2        (btn2),
        .btn3        (btn3),
        .btn5        (btn5),
        .inputCount  (inputCount),
        .flagResolve (flagResolve),
        .nameHit     (nameHit),
        .loginHit    (loginHit),
        .nameIdx     (nameIdx),
        .loginIdx    (loginIdx),
        .modes       (modes),
        .count       (count),
        .lock        (lock),
        .flag        (flag),
        .flagSelect  (flagSelect),
        .resetCount  (resetCount),
        .addEn       (addEn),
        .delEn       (delEn),
        .pwWrEn      (pwWrEn),
        .curUser     (curUser)
    );

endmodule

/* design/unlockerPkg.sv */
package unlockerPkg;

    // keypad digits and packed codes
    localparam int digitW     = 4;
    localparam int codeDigits = 4;
    localparam int codeW      = digitW * codeDigits;

    // account table sizing
    localparam int tableDepth = 8;
    localparam int idxW       = 3;
    localparam int countW     = 4;  // holds 0..tableDepth

    // inputCount levels
    localparam int fullEntry = 8;   // name and password
    localparam int nameEntry = 4;   // name only

    localparam int maxAttempts = 3;

    // reset-time admin, 1234 as nibbles
    localparam logic [codeW-1:0] defaultName     = 16'h1234;
    localparam logic [codeW-1:0] defaultPassword = 16'h1234;

    typedef enum logic [1:0]
    {
        modeAdmin = 2'd0,
        modeUser  = 2'd1,
        modeGuest = 2'd2
    } userMode_e;

    typedef enum logic [1:0]
    {
        stLocked   = 2'd0,
        stUnlocked = 2'd1,
        stFlagged  = 2'd2
    } sessionState_e;

endpackage

/* design/userTable.sv */
module userTable
    import unlockerPkg::*;
(
    input  logic              clk,
    input  logic              arstN,
    input  logic              addEn,
    input  logic              delEn,
    input  logic              pwWrEn,
    input  logic              switch1,     // 1 user, 0 guest
    input  logic [codeW-1:0]  nameCode,
    input  logic [codeW-1:0]  passwordCode,
    input  logic [idxW-1:0]   nameIdx,
    input  logic [idxW-1:0]   curUser,
    output logic [codeW-1:0]  names [tableDepth],
    output logic [codeW-1:0]  passwords [tableDepth],
    output userMode_e         modes [tableDepth],
    output logic [countW-1:0] count
);

    logic [idxW-1:0] addIdx;
    logic [idxW-1:0] lastIdx;

    assign addIdx  = count[idxW-1:0];           // first free slot
    assign lastIdx = idxW'(count - 1'b1);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < tableDepth; i++)
            begin
                names[i]     <= '0;
                passwords[i] <= '0;
                modes[i]     <= modeGuest;
            end
            names[0]     <= defaultName;
            passwords[0] <= defaultPassword;
            modes[0]     <= modeAdmin;
            count        <= countW'(1);
        end
        else if (addEn)
        begin
            names[addIdx]     <= nameCode;
            passwords[addIdx] <= passwordCode;
            modes[addIdx]     <= switch1 ? modeUser : modeGuest;
            count             <= count + 1'b1;
        end
        else if (delEn)
        begin
            // last entry fills the hole, then the last slot is wiped
            names[nameIdx]     <= names[lastIdx];
            passwords[nameIdx] <= passwords[lastIdx];
            modes[nameIdx]     <= modes[lastIdx];
            names[lastIdx]     <= '0;
            passwords[lastIdx] <= '0;
            modes[lastIdx]     <= modeGuest;
            count              <= count - 1'b1;
        end
        else if (pwWrEn)
        begin
            passwords[curUser] <= nameCode;  // new password is the entered name
        end
    end

    // session decode must never overfill the table
    addNotFull: assert property (
        @(posedge clk) disable iff (!arstN)
        addEn |-> (count != countW'(tableDepth))
    );

    // the logged-in account always survives, so one entry stays
    delNotLast: assert property (
        @(posedge clk) disable iff (!arstN)
        delEn |-> (count != countW'(1))
    );

    strobesExclusive: assert property (
        @(posedge clk) disable iff (!arstN)
        $onehot0({addEn, delEn, pwWrEn})
    );

endmodule

/* sim.f */
design/unlockerPkg.sv
design/credentialMatcher.sv
design/userTable.sv
design/sessionControl.sv
design/unlocker.sv
tb/unlockerTb.sv

/* tb/unlockerTb.sv */
module unlockerTb
    import unlockerPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic             clk;
    logic             arstN;
    logic             locker;
    logic [5:1]       btn;          // btn4 is never pressed
    logic             switch1;
    logic [3:0]       inputCount;
    logic [codeW-1:0] nameCode;     // digit 0 in the low nibble
    logic [codeW-1:0] passwordCode;
    logic             flagResolve;
    logic             lock;
    logic             flag;
    logic             flagSelect;
    logic             resetCount;

    // stimulus table, one entry per row
    int               rowTest[$];
    string            rowLabel[$];
    logic             rowLocker[$];
    logic [5:1]       rowBtn[$];
    logic             rowSwitch[$];
    logic [3:0]       rowCount[$];
    logic [codeW-1:0] rowName[$];
    logic [codeW-1:0] rowPw[$];
    logic             rowResolve[$];
    logic [3:0]       rowExp[$];    // lock, flag, flagSelect, resetCount
    logic [codeW-1:0] storedPw[$];  // passwords the table holds so far

    string       testName [1:5] = '{"reset, login and lock", "failed logins",
                                    "add accounts", "own password reset",
                                    "delete and full table"};
    int          checks = 0;
    int          fails = 0;
    int          failsAtStart = 0;
    int          cycles = 0;
    int          cycleLimit;
    logic [31:0] lcgState = 32'h0b28853b;

    unlocker i_unlocker (
        .clk            (clk),
        .arstN          (arstN),
        .locker         (locker),
        .btn1           (btn[1]),
        .btn2           (btn[2]),
        .btn3           (btn[3]),
        .btn4           (btn[4]),
        .btn5           (btn[5]),
        .switch1        (switch1),
        .inputCount     (inputCount),
        .userNameInput0 (nameCode[3:0]),
        .userNameInput1 (nameCode[7:4]),
        .userNameInput2 (nameCode[11:8]),
        .userNameInput3 (nameCode[15:12]),
        .passwordInput0 (passwordCode[3:0]),
        .passwordInput1 (passwordCode[7:4]),
        .passwordInput2 (passwordCode[11:8]),
        .passwordInput3 (passwordCode[15:12]),
        .flagResolve    (flagResolve),
        .lock           (lock),
        .flag           (flag),
        .flagSelect     (flagSelect),
        .resetCount     (resetCount)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit)
        begin
            $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // four decimal digits from the top byte of each draw
    function automatic logic [codeW-1:0] randomCode();
        logic [codeW-1:0] code;
        logic [31:0]      r;
        for (int k = 0; k < codeDigits; k++)
        begin
            r = nextRandom();
            code[4*k +: 4] = 4'(r[31:24] % 10);
        end
        return code;
    endfunction

    function automatic bit isStored(logic [codeW-1:0] code);
        foreach (storedPw[i])
        begin
            if (storedPw[i] == code)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [codeW-1:0] wrongPassword();
        logic [codeW-1:0] code;
        code = randomCode();
        while (isStored(code))
            code = randomCode();
        return code;
    endfunction

    task automatic addRow(int t, string lbl, logic lk, logic [5:1] b, logic sw,
                          logic [3:0] cnt, logic [codeW-1:0] nm, logic [codeW-1:0] pw,
                          logic rs, logic [3:0] e);
        rowTest.push_back(t);
        rowLabel.push_back(lbl);
        rowLocker.push_back(lk);
        rowBtn.push_back(b);
        rowSwitch.push_back(sw);
        rowCount.push_back(cnt);
        rowName.push_back(nm);
        rowPw.push_back(pw);
        rowResolve.push_back(rs);
        rowExp.push_back(e);
        if (e[0] && b[3])
            storedPw.push_back(pw);
        if (e[0] && b[2])
            storedPw.push_back(nm);   // own reset stores the name as password
    endtask

    task automatic loginRow(int t, string lbl, logic [codeW-1:0] nm, logic [codeW-1:0] pw,
                            logic [3:0] e);
        addRow(t, lbl, 0, 5'b00000, 0, 4'(fullEntry), nm, pw, 0, e);
    endtask

    task automatic lockRow(int t);
        addRow(t, "btn1 lock", 0, 5'b00001, 0, 0, 0, 0, 0, 4'b1000);
    endtask

    task automatic resolveRow(int t);
        addRow(t, "flag resolve", 0, 5'b00000, 0, 0, 0, 0, 1, 4'b1000);
    endtask

    task automatic buildTable();
        storedPw.push_back(defaultPassword);
        addRow(1, "idle after reset", 0, 5'b00000, 0, 0, 0, 0, 0, 4'b1000);
        loginRow(1, "admin login", 16'h1234, 16'h1234, 4'b0001);
        lockRow(1);
        loginRow(2, "wrong login 1", 16'h1234, wrongPassword(), 4'b1101);
        resolveRow(2);
        loginRow(2, "wrong login 2", 16'h1234, wrongPassword(), 4'b1101);
        resolveRow(2);
        loginRow(2, "wrong login 3", 16'h1234, wrongPassword(), 4'b1111);
        resolveRow(2);
        loginRow(2, "admin login", 16'h1234, 16'h1234, 4'b0001);
        // admin is still logged in here
        addRow(3, "add user", 0, 5'b00100, 1, 4'(fullEntry), 16'h2580, 16'h1357, 0, 4'b0001);
        addRow(3, "add guest", 0, 5'b00100, 0, 4'(fullEntry), 16'h3690, 16'h2468, 0, 4'b0001);
        addRow(3, "add same name", 0, 5'b00100, 1, 4'(fullEntry), 16'h2580, 16'h1111, 0, 4'b0000);
        addRow(3, "locker lock", 1, 5'b00000, 0, 0, 0, 0, 0, 4'b1000);
        loginRow(3, "user login", 16'h2580, 16'h1357, 4'b0001);
        lockRow(3);
        loginRow(3, "guest login", 16'h3690, 16'h2468, 4'b0001);
        lockRow(3);
        loginRow(4, "user login", 16'h2580, 16'h1357, 4'b0001);
        addRow(4, "user btn2", 0, 5'b00010, 0, 4'(nameEntry), 16'h2580, 0, 0, 4'b0001);
        lockRow(4);
        loginRow(4, "user old password", 16'h2580, 16'h1357, 4'b1101);
        resolveRow(4);
        loginRow(4, "user name as password", 16'h2580, 16'h2580, 4'b0001);
        lockRow(4);
        loginRow(4, "guest login", 16'h3690, 16'h2468, 4'b0001);
        addRow(4, "guest btn2", 0, 5'b00010, 0, 4'(nameEntry), 16'h3690, 0, 0, 4'b0000);
        lockRow(4);
        loginRow(4, "guest old password", 16'h3690, 16'h2468, 4'b0001);
        lockRow(4);
        loginRow(5, "admin login", 16'h1234, 16'h1234, 4'b0001);
        addRow(5, "delete user", 0, 5'b10000, 0, 4'(nameEntry), 16'h2580, 0, 0, 4'b0001);
        addRow(5, "delete self", 0, 5'b10000, 0, 4'(nameEntry), 16'h1234, 0, 0, 4'b0000);
        for (int i = 0; i < 6; i++)
        begin
            // admin and guest hold two slots, six more fill the table
            addRow(5, "fill table", 0, 5'b00100, i[0], 4'(fullEntry),
                   16'h4100 | 16'(i), 16'h5100 | 16'(i), 0, 4'b0001);
        end
        addRow(5, "ninth add", 0, 5'b00100, 1, 4'(fullEntry), 16'h4199, 16'h5199, 0, 4'b0000);
        lockRow(5);
        loginRow(5, "deleted user login", 16'h2580, 16'h2580, 4'b1101);
        resolveRow(5);
    endtask

    task automatic clearInputs();
        locker       <= 1'b0;
        btn          <= '0;
        switch1      <= 1'b0;
        inputCount   <= '0;
        nameCode     <= '0;
        passwordCode <= '0;
        flagResolve  <= 1'b0;
    endtask

    task automatic driveRow(int r);
        locker       <= rowLocker[r];
        btn          <= rowBtn[r];
        switch1      <= rowSwitch[r];
        inputCount   <= rowCount[r];
        nameCode     <= rowName[r];
        passwordCode <= rowPw[r];
        flagResolve  <= rowResolve[r];
    endtask

    task automatic checkBit(string sig, logic act, logic exp, int r);
        checks++;
        assert (act === exp)
        else
        begin
            $display("[FAIL] test %0d %s: %s expected %h got %h",
                     rowTest[r], rowLabel[r], sig, exp, act);
            fails++;
        end
    endtask

    initial
    begin
        clk   = 1'b0;
        arstN = 1'b0;
        clearInputs();
        buildTable();
        cycleLimit = 16 + 3 * rowTest.size() + 50;
        repeat (16) @(posedge clk);
        arstN <= 1'b1;
        for (int r = 0; r < rowTest.size(); r++)
        begin
            @(posedge clk);
            driveRow(r);
            @(posedge clk);             // action edge
            clearInputs();
            @(negedge clk);
            checkBit("lock", lock, rowExp[r][3], r);
            checkBit("flag", flag, rowExp[r][2], r);
            checkBit("flagSelect", flagSelect, rowExp[r][1], r);
            checkBit("resetCount", resetCount, rowExp[r][0], r);
            if (r == rowTest.size() - 1 || rowTest[r + 1] != rowTest[r])
            begin
                $display("test %0d %s: %0d failed checks", rowTest[r],
                         testName[rowTest[r]], fails - failsAtStart);
                failsAtStart = fails;
            end
        end
        $display("checks passed %0d, failed %0d", checks - fails, fails);
        if (fails == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
